// ==== verilog.f ====
+incdir+include
verilog/ac_pkg.sv
verilog/operate_unit.sv
verilog/memref_unit.sv
verilog/eae_muldiv.sv
verilog/ac_regs.sv
verilog/ac_top.sv
verif/ac_tb.sv

// ==== verif/ac_tb.sv ====
/*
 * Directed testbench for the accumulator section. Steps the DUT through
 * sequencer phases for operate, memory-reference and EAE instructions.
 */
`timescale 1ns/100ps
`include "ac_defs.svh"

module ac_tb;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 8;
    localparam int LOOP_STEPS   = 12;
    localparam int LOAD_CYCLES  = 7;    // worst case of load_registers
    localparam int ROUNDS       = 4;    // random rounds per arithmetic test

    localparam int CLEAR_TEST   = LOAD_CYCLES + 3;
    localparam int GROUP1_TEST  = (16 + 3 + 10) * (LOAD_CYCLES + 1);
    localparam int GROUP3_TEST  = 6 * (LOAD_CYCLES + 1);
    localparam int MEMREF_TEST  = ROUNDS * (LOAD_CYCLES + 7);
    localparam int EAE_RUN      = LOAD_CYCLES + 1 + LOOP_STEPS;
    localparam int MUL_TEST     = ROUNDS * EAE_RUN;
    localparam int DIV_TEST     = ROUNDS * EAE_RUN + 2 * (LOAD_CYCLES + 3);
    localparam int TOTAL_CYCLES = RESET_CYCLES + CLEAR_TEST + GROUP1_TEST + GROUP3_TEST
                                + MEMREF_TEST + MUL_TEST + DIV_TEST;
    localparam int WATCHDOG_NS  = 2 * TOTAL_CYCLES * CLK_PERIOD;

    // operate words in octal as in the machine manual
    localparam logic [11:0] CLA_CLL = 12'o7300;
    localparam logic [11:0] CML     = 12'o7020;
    localparam logic [11:0] IAC     = 12'o7001;
    localparam logic [11:0] RAL     = 12'o7004;
    localparam logic [11:0] RTL     = 12'o7006;
    localparam logic [11:0] RAR     = 12'o7010;
    localparam logic [11:0] RTR     = 12'o7012;
    localparam logic [11:0] BSW     = 12'o7002;
    localparam logic [11:0] MQL     = 12'o7421;
    localparam logic [11:0] MQA     = 12'o7501;
    localparam logic [11:0] SWP     = 12'o7521;
    localparam logic [11:0] CAM     = 12'o7621;
    localparam logic [11:0] ACL     = 12'o7701;
    localparam logic [11:0] CLA_SWP = 12'o7721;

    localparam logic [11:0] AND_INSTR = {`OP_AND, 9'o123};
    localparam logic [11:0] TAD_INSTR = {`OP_TAD, 9'o100};
    localparam logic [11:0] DCA_INSTR = {`OP_DCA, 9'o050};

    logic           clk;
    logic           reset;
    ac_pkg::phase_t phase;
    ac_pkg::word_t  instruction;
    ac_pkg::word_t  mdout;
    logic           clear;
    logic           link;
    ac_pkg::word_t  ac;
    ac_pkg::word_t  mq;
    logic           eae_loop;

    string          test_name;
    int unsigned    first_draw;

    ac_top dut_i (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .clear       (clear),
        .link        (link),
        .ac          (ac),
        .mq          (mq),
        .eae_loop    (eae_loop)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [11:0] random_word();
        logic [31:0] r;
        r = $urandom;
        return r[11:0];
    endfunction

    function automatic logic random_bit();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED test %s, %s: expected %0o, actual %0o",
                     test_name, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic stop_with_failure(input string msg);
        $display("test %s: %s", test_name, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped on failure");
    endtask

    task automatic expect_regs(input string what, input logic l, input logic [11:0] a,
                               input logic [11:0] m);
        check_value({what, " link"}, l, link);
        check_value({what, " ac"}, a, ac);
        check_value({what, " mq"}, m, mq);
    endtask

    // one phase for one cycle with results readable on return
    task automatic apply_phase(input ac_pkg::phase_t p);
        phase = p;
        @(posedge clk);
        #DRIVE_DELAY;
        phase = ac_pkg::IDLE;
    endtask

    task automatic apply_operate(input logic [11:0] code, input ac_pkg::phase_t p);
        instruction = code;
        apply_phase(p);
    endtask

    task automatic tad_operand(input logic [11:0] value);
        instruction = TAD_INSTR;
        mdout       = value;
        apply_phase(ac_pkg::E1);
        apply_phase(ac_pkg::E2);
    endtask

    // cla cll, tad m, mql, tad a, then cml if needed
    task automatic load_registers(input logic l, input logic [11:0] a, input logic [11:0] m);
        apply_operate(CLA_CLL, ac_pkg::F1);
        tad_operand(m);
        apply_operate(MQL, ac_pkg::F1);
        tad_operand(a);
        if (l)
            apply_operate(CML, ac_pkg::F1);
        expect_regs("load", l, a, m);
    endtask

    task automatic load_random_registers(output logic l, output logic [11:0] a,
                                         output logic [11:0] m);
        l = random_bit();
        a = random_word();
        m = random_word();
        load_registers(l, a, m);
    endtask

    task automatic run_eae_loop();
        int steps;
        steps = 0;
        if (!eae_loop)
            stop_with_failure("eae_loop did not rise after EAE0");
        else
        begin
            while (eae_loop)
            begin
                if (steps == LOOP_STEPS)
                    stop_with_failure("eae_loop still high after 12 EAE1 cycles");
                else
                begin
                    apply_phase(ac_pkg::EAE1);
                    steps++;
                end
            end
        end
        check_value("loop steps", LOOP_STEPS, steps);
    endtask

    task automatic rotate_case(input string what, input logic [11:0] code, input bit left,
                               input int count);
        logic        l;
        logic [11:0] a;
        logic [11:0] m;
        logic [12:0] v;
        load_random_registers(l, a, m);
        apply_operate(code, ac_pkg::F3);
        v = {l, a};                                 // rotate through the link
        repeat (count)
            v = left ? {v[11:0], v[12]} : {v[0], v[12:1]};
        expect_regs(what, v[12], v[11:0], m);
    endtask

    task automatic reset_clear_test();
        logic [11:0] a;
        logic [11:0] m;
        test_name = "reset_clear";
        check_value("eae_loop", 0, eae_loop);
        expect_regs("after reset", 1'b0, 12'o0000, 12'o0000);
        a = random_word() | 12'o0001;
        m = random_word() | 12'o4000;
        load_registers(1'b1, a, m);
        clear = 1'b1;
        apply_phase(ac_pkg::IDLE);                  // clear ignored outside H2
        expect_regs("clear in idle", 1'b1, a, m);
        clear = 1'b0;
        apply_phase(ac_pkg::H2);
        expect_regs("h2 no clear", 1'b1, a, m);
        clear = 1'b1;
        apply_phase(ac_pkg::H2);
        clear = 1'b0;
        expect_regs("h2 clear", 1'b0, 12'o0000, 12'o0000);
    endtask

    task automatic group1_test();
        int          k;
        int          total;
        logic [3:0]  sel;
        logic        l;
        logic        el;
        logic [11:0] a;
        logic [11:0] ea;
        logic [11:0] m;
        test_name = "group1";
        for (k = 0; k < 16; k++)
        begin
            sel = k[3:0];                           // cla cll cma cml
            load_random_registers(l, a, m);
            apply_operate(12'o7000 | {4'b0000, sel, 4'b0000}, ac_pkg::F1);
            ea = sel[3] ? 12'o0000 : a;
            el = sel[2] ? 1'b0 : l;
            if (sel[1])
                ea = ~ea;
            if (sel[0])
                el = ~el;
            expect_regs("clear/complement", el, ea, m);
        end
        for (k = 0; k < 3; k++)
        begin
            l = (k == 1);
            a = (k == 2) ? random_word() : 12'o7777;
            m = random_word();
            load_registers(l, a, m);
            apply_operate(IAC, ac_pkg::F2);
            total = ((l ? 4096 : 0) + a + 1) % 8192;
            expect_regs("iac", total[12], total[11:0], m);
        end
        for (k = 0; k < 2; k++)
        begin
            rotate_case("ral", RAL, 1'b1, 1);
            rotate_case("rtl", RTL, 1'b1, 2);
            rotate_case("rar", RAR, 1'b0, 1);
            rotate_case("rtr", RTR, 1'b0, 2);
            load_random_registers(l, a, m);
            apply_operate(BSW, ac_pkg::F3);
            expect_regs("bsw", l, {a[5:0], a[11:6]}, m);
        end
    endtask

    task automatic group3_test();
        logic        l;
        logic [11:0] a;
        logic [11:0] m;
        test_name = "group3";
        load_random_registers(l, a, m);
        apply_operate(MQL, ac_pkg::F1);
        expect_regs("mql", l, 12'o0000, a);
        load_random_registers(l, a, m);
        apply_operate(MQA, ac_pkg::F1);
        expect_regs("mqa", l, a | m, m);
        load_random_registers(l, a, m);
        apply_operate(SWP, ac_pkg::F1);
        expect_regs("swp", l, m, a);
        load_random_registers(l, a, m);
        apply_operate(CAM, ac_pkg::F1);
        expect_regs("cam", l, 12'o0000, 12'o0000);
        load_random_registers(l, a, m);
        apply_operate(ACL, ac_pkg::F1);
        expect_regs("acl", l, m, m);
        load_random_registers(l, a, m);
        apply_operate(CLA_SWP, ac_pkg::F1);
        expect_regs("cla swp", l, m, 12'o0000);
    endtask

    task automatic memref_test();
        int          k;
        int          total;
        logic        l;
        logic [11:0] a;
        logic [11:0] m;
        logic [11:0] op;
        test_name = "memref";
        for (k = 0; k < ROUNDS; k++)
        begin
            load_random_registers(l, a, m);
            op          = random_word();
            instruction = AND_INSTR;
            mdout       = op;
            apply_phase(ac_pkg::E1);
            mdout = ~op;                            // E2 must use the latched operand
            apply_phase(ac_pkg::E2);
            a = a & op;
            expect_regs("and", l, a, m);
            op = random_word();
            tad_operand(op);
            total = a + op;
            if (total > 4095)
                l = ~l;                             // carry complements link
            a = total[11:0];
            expect_regs("tad", l, a, m);
            instruction = DCA_INSTR;
            mdout       = random_word();
            apply_phase(ac_pkg::E1);
            apply_phase(ac_pkg::E2);
            apply_phase(ac_pkg::E3);
            expect_regs("dca", l, 12'o0000, m);
        end
    endtask

    task automatic multiply_test();
        int          k;
        int          product;
        logic        l;
        logic [11:0] a;
        logic [11:0] m;
        logic [11:0] md;
        test_name = "multiply";
        for (k = 0; k < ROUNDS; k++)
        begin
            load_random_registers(l, a, m);
            md          = random_word();
            instruction = `OPR_MUL;
            mdout       = md;
            apply_phase(ac_pkg::EAE0);
            check_value("link after eae0", 0, link);
            run_eae_loop();
            product = m * md + a;
            check_value("ac:mq", product, {ac, mq});
            check_value("link", 0, link);
        end
    endtask

    task automatic divide_test();
        int          k;
        int          dividend;
        int          total;
        logic        l;
        logic [11:0] a;
        logic [11:0] m;
        logic [11:0] md;
        test_name = "divide";
        for (k = 0; k < ROUNDS; k++)
        begin
            md = random_word();
            if (md == 12'o0000)
                md = 12'o0001;
            l = random_bit();
            a = random_word() % md;                 // keeps ac below the divisor
            m = random_word();
            load_registers(l, a, m);
            instruction = `OPR_DIV;
            mdout       = md;
            apply_phase(ac_pkg::EAE0);
            check_value("link after eae0", 0, link);
            run_eae_loop();
            dividend = a * 4096 + m;
            expect_regs("quotient", 1'b0, dividend % md, dividend / md);
        end
        for (k = 0; k < 2; k++)
        begin
            md    = random_word();
            total = md + (random_word() % (4096 - md));
            a     = total[11:0];                    // ac not less than divisor
            l     = random_bit();
            m     = random_word();
            load_registers(l, a, m);
            instruction = `OPR_DIV;
            mdout       = md;
            apply_phase(ac_pkg::EAE0);
            expect_regs("overflow", 1'b1, a, m);
            check_value("eae_loop on overflow", 0, eae_loop);
            apply_phase(ac_pkg::IDLE);
            check_value("eae_loop after overflow", 0, eae_loop);
            apply_phase(ac_pkg::IDLE);
            check_value("eae_loop after overflow", 0, eae_loop);
            expect_regs("overflow hold", 1'b1, a, m);
        end
    endtask

    initial
    begin
        first_draw  = $urandom(8992);
        test_name   = "none";
        reset       = 1'b1;
        phase       = ac_pkg::IDLE;
        instruction = '0;
        mdout       = '0;
        clear       = 1'b0;
        repeat (RESET_CYCLES)
            @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b0;
        reset_clear_test();
        group1_test();
        group3_test();
        memref_test();
        multiply_test();
        divide_test();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== verilog/ac_top.sv ====
/*
 * Accumulator section top level. Operate, memory-reference and EAE units
 * feed next values into the shared link, ac and mq register block.
 */
`timescale 1ns/100ps

module ac_top (
    input  logic           clk,
    input  logic           reset,
    input  ac_pkg::phase_t phase,
    input  ac_pkg::word_t  instruction,
    input  ac_pkg::word_t  mdout,
    input  logic           clear,
    output logic           link,
    output ac_pkg::word_t  ac,
    output ac_pkg::word_t  mq,
    output logic           eae_loop
);

    logic          opr_ld;
    logic          opr_link;
    ac_pkg::word_t opr_ac;
    ac_pkg::word_t opr_mq;
    logic          mem_ld_ac;
    logic          mem_ld_link;
    ac_pkg::word_t mem_ac;
    logic          mem_link;
    logic          eae_ld;
    logic          eae_link;
    ac_pkg::word_t eae_ac;
    ac_pkg::word_t eae_mq;

    operate_unit operate_i (
        .phase       (phase),
        .instruction (instruction),
        .link        (link),
        .ac          (ac),
        .mq          (mq),
        .opr_ld      (opr_ld),
        .opr_link    (opr_link),
        .opr_ac      (opr_ac),
        .opr_mq      (opr_mq)
    );

    memref_unit memref_i (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .link        (link),
        .ac          (ac),
        .mem_ld_ac   (mem_ld_ac),
        .mem_ld_link (mem_ld_link),
        .mem_ac      (mem_ac),
        .mem_link    (mem_link)
    );

    eae_muldiv eae_i (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .mdout       (mdout),
        .link        (link),
        .ac          (ac),
        .mq          (mq),
        .eae_loop    (eae_loop),
        .eae_ld      (eae_ld),
        .eae_link    (eae_link),
        .eae_ac      (eae_ac),
        .eae_mq      (eae_mq)
    );

    ac_regs regs_i (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .clear       (clear),
        .opr_ld      (opr_ld),
        .opr_link    (opr_link),
        .opr_ac      (opr_ac),
        .opr_mq      (opr_mq),
        .mem_ld_ac   (mem_ld_ac),
        .mem_ld_link (mem_ld_link),
        .mem_ac      (mem_ac),
        .mem_link    (mem_link),
        .eae_ld      (eae_ld),
        .eae_link    (eae_link),
        .eae_ac      (eae_ac),
        .eae_mq      (eae_mq),
        .link        (link),
        .ac          (ac),
        .mq          (mq)
    );

endmodule

// ==== verilog/ac_regs.sv ====
/*
 * Link, accumulator and mq registers. Loads from whichever unit strobes
 * and zeroes all three on reset or on the H2 clear pulse.
 */
`timescale 1ns/100ps

module ac_regs (
    input  logic           clk,
    input  logic           reset,
    input  ac_pkg::phase_t phase,
    input  logic           clear,
    input  logic           opr_ld,
    input  logic           opr_link,
    input  ac_pkg::word_t  opr_ac,
    input  ac_pkg::word_t  opr_mq,
    input  logic           mem_ld_ac,
    input  logic           mem_ld_link,
    input  ac_pkg::word_t  mem_ac,
    input  logic           mem_link,
    input  logic           eae_ld,
    input  logic           eae_link,
    input  ac_pkg::word_t  eae_ac,
    input  ac_pkg::word_t  eae_mq,
    output logic           link,
    output ac_pkg::word_t  ac,
    output ac_pkg::word_t  mq
);

    logic clear_now;

    assign clear_now = clear && (phase == ac_pkg::H2);

    always_ff @(posedge clk)
    begin
        if (reset || clear_now)
        begin
            link <= 1'b0;
            ac   <= '0;
            mq   <= '0;
        end
        else if (opr_ld)
        begin
            link <= opr_link;
            ac   <= opr_ac;
            mq   <= opr_mq;
        end
        else if (eae_ld)
        begin
            link <= eae_link;
            ac   <= eae_ac;
            mq   <= eae_mq;
        end
        else
        begin
            if (mem_ld_ac)
                ac <= mem_ac;
            if (mem_ld_link)
                link <= mem_link;   // tad carry
        end
    end

endmodule

// ==== verilog/eae_muldiv.sv ====
/*
 * Extended arithmetic, mode A multiply and divide. EAE0 sets up the loop,
 * then each EAE1 cycle does one shift-add or shift-subtract step.
 */
`timescale 1ns/100ps
`include "ac_defs.svh"

module eae_muldiv (
    input  logic           clk,
    input  logic           reset,
    input  ac_pkg::phase_t phase,
    input  ac_pkg::word_t  instruction,
    input  ac_pkg::word_t  mdout,
    input  logic           link,
    input  ac_pkg::word_t  ac,
    input  ac_pkg::word_t  mq,
    output logic           eae_loop,
    output logic           eae_ld,
    output logic           eae_link,
    output ac_pkg::word_t  eae_ac,
    output ac_pkg::word_t  eae_mq
);

    ac_pkg::sc_t   sc;          // steps left
    ac_pkg::word_t eae_op;
    logic          is_mul;
    logic          is_div;
    logic [0:12]   mul_sum;     // ac + mdout with carry
    logic [0:12]   div_ov;      // borrow in bit 0 means no overflow
    logic [0:12]   div_temp;    // trial subtract of the shifted remainder

    assign eae_op   = instruction & `EAE_MASK;
    assign is_mul   = (eae_op == `OPR_MUL);
    assign is_div   = (eae_op == `OPR_DIV);
    assign mul_sum  = {1'b0, ac} + {1'b0, mdout};
    assign div_ov   = {1'b0, ac} - {1'b0, mdout};
    assign div_temp = {ac, mq[0]} - {1'b0, mdout};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            eae_loop <= 1'b0;
            sc       <= '0;
        end
        else if (phase == ac_pkg::EAE0)
        begin
            if (is_mul || (is_div && div_ov[0]))
            begin
                eae_loop <= 1'b1;
                sc       <= ac_pkg::sc_t'(`MULDIV_STEPS);
            end
        end
        else if ((phase == ac_pkg::EAE1) && eae_loop)
        begin
            sc <= sc - ac_pkg::sc_t'(1);
            if (sc == ac_pkg::sc_t'(1))
                eae_loop <= 1'b0;           // last step taken
        end
    end

    always_comb
    begin
        eae_ld   = 1'b0;
        eae_link = link;
        eae_ac   = ac;
        eae_mq   = mq;
        if (phase == ac_pkg::EAE0)
        begin
            if (is_mul)
            begin
                eae_ld   = 1'b1;
                eae_link = 1'b0;
            end
            else if (is_div)
            begin
                eae_ld   = 1'b1;
                eae_link = ~div_ov[0];      // ac >= divisor is overflow
            end
        end
        else if ((phase == ac_pkg::EAE1) && eae_loop)
        begin
            if (is_mul)
            begin
                eae_ld = 1'b1;
                if (mq[11])
                begin
                    eae_ac = mul_sum[0:11];             // add then shift right
                    eae_mq = {mul_sum[12], mq[0:10]};
                end
                else
                begin
                    eae_ac = {1'b0, ac[0:10]};
                    eae_mq = {ac[11], mq[0:10]};
                end
            end
            else if (is_div)
            begin
                eae_ld = 1'b1;
                if (!div_temp[0])
                begin
                    eae_ac = div_temp[1:12];            // subtract fits, quotient bit 1
                    eae_mq = {mq[1:11], 1'b1};
                end
                else
                begin
                    eae_ac = {ac[1:11], mq[0]};         // restore, just shift
                    eae_mq = {mq[1:11], 1'b0};
                end
            end
        end
    end

endmodule

// ==== verilog/memref_unit.sv ====
/*
 * Memory-reference execute. Latches the operand in E1, forms AND and TAD
 * in E2 and clears ac for DCA in E3.
 */
`timescale 1ns/100ps
`include "ac_defs.svh"

module memref_unit (
    input  logic           clk,
    input  logic           reset,
    input  ac_pkg::phase_t phase,
    input  ac_pkg::word_t  instruction,
    input  ac_pkg::word_t  mdout,
    input  logic           link,
    input  ac_pkg::word_t  ac,
    output logic           mem_ld_ac,
    output logic           mem_ld_link,
    output ac_pkg::word_t  mem_ac,
    output logic           mem_link
);

    ac_pkg::word_t operand;
    logic          operand_valid;   // set in E1, used up in E2
    logic [0:2]    opcode;
    logic [0:12]   tad_sum;

    assign opcode  = instruction[0:2];
    assign tad_sum = {link, ac} + {1'b0, operand};

    always_ff @(posedge clk)
    begin
        if (phase == ac_pkg::E1)
            operand <= mdout;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            operand_valid <= 1'b0;
        else if (phase == ac_pkg::E1)
            operand_valid <= 1'b1;
        else if (phase == ac_pkg::E2)
            operand_valid <= 1'b0;
    end

    always_comb
    begin
        mem_ld_ac   = 1'b0;
        mem_ld_link = 1'b0;
        mem_ac      = ac;
        mem_link    = link;
        if ((phase == ac_pkg::E2) && operand_valid)
        begin
            if (opcode == `OP_AND)
            begin
                mem_ld_ac = 1'b1;
                mem_ac    = ac & operand;
            end
            else if (opcode == `OP_TAD)
            begin
                mem_ld_ac            = 1'b1;
                mem_ld_link          = 1'b1;
                {mem_link, mem_ac}   = tad_sum;    // carry flips into link
            end
        end
        else if ((phase == ac_pkg::E3) && (opcode == `OP_DCA))
        begin
            mem_ld_ac = 1'b1;                      // store happened, ac cleared
            mem_ac    = '0;
        end
    end

endmodule

// ==== verilog/operate_unit.sv ====
/*
 * Operate instruction decode. Applies group-1 and group-3 microinstructions
 * in phases F1, F2 and F3 and presents the next link, ac and mq.
 */
`timescale 1ns/100ps
`include "ac_defs.svh"

module operate_unit (
    input  ac_pkg::phase_t phase,
    input  ac_pkg::word_t  instruction,
    input  logic           link,
    input  ac_pkg::word_t  ac,
    input  ac_pkg::word_t  mq,
    output logic           opr_ld,
    output logic           opr_link,
    output ac_pkg::word_t  opr_ac,
    output ac_pkg::word_t  opr_mq
);

    logic          grp1;
    logic          grp3;
    logic [0:2]    rot;
    logic          g1_link;
    ac_pkg::word_t g1_ac;
    ac_pkg::word_t g3_cla_ac;   // ac after the group-3 clear
    ac_pkg::word_t g3_ac;
    ac_pkg::word_t g3_mq;
    logic [0:12]   inc_sum;

    assign grp1 = (instruction[0:3] == `OPR_GRP1);
    assign grp3 = (instruction[0:3] == `OPR_GRP3) && instruction[11];
    assign rot  = instruction[8:10];

    // group 1, clear before complement
    always_comb
    begin
        g1_ac   = instruction[4] ? '0 : ac;         // cla
        g1_link = instruction[5] ? 1'b0 : link;     // cll
        if (instruction[6])
            g1_ac = ~g1_ac;                         // cma
        if (instruction[7])
            g1_link = ~g1_link;                     // cml
    end

    // group 3: bit 4 cla, bit 5 mqa, bit 7 mql
    // these combine into swp, cam, acl and cla swp
    assign g3_cla_ac = instruction[4] ? '0 : ac;
    assign g3_ac     = (instruction[5] ? mq : '0) | (instruction[7] ? '0 : g3_cla_ac);
    assign g3_mq     = instruction[7] ? g3_cla_ac : mq;

    assign inc_sum = {link, ac} + 13'd1;            // carry out lands in link

    always_comb
    begin
        opr_ld   = 1'b0;
        opr_link = link;
        opr_ac   = ac;
        opr_mq   = mq;
        case (phase)
            ac_pkg::F1:
            begin
                if (grp1)
                begin
                    opr_ld   = 1'b1;
                    opr_link = g1_link;
                    opr_ac   = g1_ac;
                end
                else if (grp3)
                begin
                    opr_ld = 1'b1;
                    opr_ac = g3_ac;
                    opr_mq = g3_mq;
                end
            end
            ac_pkg::F2:
            begin
                if (grp1 && instruction[11])            // iac
                begin
                    opr_ld              = 1'b1;
                    {opr_link, opr_ac}  = inc_sum;
                end
            end
            ac_pkg::F3:
            begin
                if (grp1)
                begin
                    opr_ld = 1'b1;
                    case (rot)
                        `ROT_BSW: opr_ac = {ac[6:11], ac[0:5]};
                        `ROT_RAL: {opr_link, opr_ac} = {ac, link};
                        `ROT_RTL: {opr_link, opr_ac} = {ac[1:11], link, ac[0]};
                        `ROT_RAR: {opr_link, opr_ac} = {ac[11], link, ac[0:10]};
                        `ROT_RTR: {opr_link, opr_ac} = {ac[10:11], link, ac[0:9]};
                        default:  opr_ld = 1'b0;    // no shift coded
                    endcase
                end
            end
            default:;
        endcase
    end

endmodule

// ==== verilog/ac_pkg.sv ====
/*
 * Shared types of the accumulator section: the machine word, the EAE
 * step count and the machine-cycle phase code driven by the sequencer.
 */
`include "ac_defs.svh"

package ac_pkg;

    // bit 0 is the most significant bit
    typedef logic [0:`AC_WIDTH-1] word_t;

    typedef logic [`SC_WIDTH-1:0] sc_t;

    typedef enum logic [4:0]
    {
        F0,     // fetch setup
        FW,     // fetch wait
        F1,     // clear and complement, mq transfers
        F2,     // increment
        F3,     // rotates and byte swap
        E1,     // memory operand valid
        E2,     // and, tad
        E3,     // dca
        H2,     // clear pulse sampled here
        EAE0,   // mul/div setup
        EAE1,   // one mul/div step
        IDLE
    } phase_t;

endpackage

// ==== include/ac_defs.svh ====
/*
 * Accumulator section constants: word and step-count widths, memory-reference
 * opcodes, operate-group match codes and the EAE loop length.
 */
`ifndef AC_DEFS_SVH
`define AC_DEFS_SVH

`define AC_WIDTH      12
`define SC_WIDTH      5

// memory-reference opcodes, instruction bits 0:2
`define OP_AND        3'o0
`define OP_TAD        3'o1
`define OP_DCA        3'o3

// operate groups, instruction bits 0:3
`define OPR_GRP1      4'b1110
`define OPR_GRP3      4'b1111   // group 3 also needs bit 11 set

// group-1 rotate field, instruction bits 8:10
`define ROT_BSW       3'b001
`define ROT_RAL       3'b010
`define ROT_RTL       3'b011
`define ROT_RAR       3'b100
`define ROT_RTR       3'b101

// extended arithmetic
`define EAE_MASK      12'o7417
`define OPR_MUL       12'o7405
`define OPR_DIV       12'o7407
`define MULDIV_STEPS  12

`endif
